// ==== include/zkbd_defs.svh ====
// widths, spi command codes and port numbers
// for the keyboard, mouse and joystick input path
`ifndef ZKBD_DEFS_SVH
`define ZKBD_DEFS_SVH

`define KBD_BITS  40 // 8 half-rows of 5 keys
`define KBD_BYTES 5  // data bytes in one keyboard frame

// set to 1 for an 8-bit kempston register, 0 keeps the classic 5 bits
`define KEMPSTON_8BIT 0
`define KJ_BITS ((`KEMPSTON_8BIT != 0) ? 8 : 5)

// command bytes from the supervisor mcu
`define CMD_KBD    8'h10
`define CMD_MUSX   8'h20
`define CMD_MUSY   8'h21
`define CMD_MUSBTN 8'h22
`define CMD_KJ     8'h23

// cpu port numbers, low byte
`define PORT_KBD_LO 8'hFE
`define PORT_KJ     8'h1F
`define PORT_MUS_LO 8'hDF // high byte FA, FB or FF picks the mouse register

`endif

// ==== hdl/zkbd_pkg.sv ====
// shared types of the input path
// vector typedefs and the spi receiver state encoding
`include "zkbd_defs.svh"

package zkbd_pkg;

	// key state, one bit per key, 1 = pressed
	typedef logic [`KBD_BITS-1:0] kbd_matrix_t;

	// half-row answer as the cpu sees it, active low
	typedef logic [4:0] kbd_row_t;

	// mouse coordinate, button byte or raw spi byte
	typedef logic [7:0] mus_byte_t;

	typedef logic [`KJ_BITS-1:0] kj_t; // kempston joystick bits

	typedef logic [15:0] port_addr_t; // full z80 i/o address
	typedef logic [7:0]  zah_t;       // address high byte

	// spi frame decoder
	typedef enum logic [1:0] {
		S_IDLE, // cs high
		S_CMD,  // waiting for the command byte
		S_DATA, // collecting data bytes
		S_SKIP  // ignore the rest of the frame
	} spi_state_t;

endpackage

// ==== hdl/slavespi.sv ====
// spi slave for the supervisor mcu link
// pin synchronizers, byte shifter and frame decoder making the load strobes
`timescale 1ns/1ps
`include "zkbd_defs.svh"

module slavespi (
	input  logic                  fclk,
	input  logic                  arst_n,
	input  logic                  spi_cs_n,
	input  logic                  spi_sck,
	input  logic                  spi_mosi,
	output zkbd_pkg::kbd_matrix_t kbd_in,
	output logic                  kbd_stb,
	output zkbd_pkg::mus_byte_t   mus_in,
	output logic                  mus_xstb,
	output logic                  mus_ystb,
	output logic                  mus_btnstb,
	output logic                  kj_stb
);
	import zkbd_pkg::*;

	logic [1:0]  cs_sync;   // cs_n into fclk
	logic [2:0]  sck_sync;  // third stage for edge detect
	logic [1:0]  mosi_sync; // same depth as sck so data lines up
	logic        cs_act;
	logic        sck_rise;
	mus_byte_t   sr;        // shift register, msb first
	logic [2:0]  bit_cnt;
	logic        byte_vld;  // sr holds a full byte this cycle
	spi_state_t  state;
	mus_byte_t   cmd;       // latched command byte
	logic [2:0]  byte_cnt;  // data bytes seen in this frame
	kbd_matrix_t kbd_hold;  // keyboard frame collects here

	// two-flop synchronizers
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cs_sync   <= '1; // deselected
			sck_sync  <= '0;
			mosi_sync <= '0;
		end
		else
		begin
			cs_sync   <= {cs_sync[0], spi_cs_n};
			sck_sync  <= {sck_sync[1:0], spi_sck};
			mosi_sync <= {mosi_sync[0], spi_mosi};
		end
	end

	assign cs_act   = ~cs_sync[1];
	assign sck_rise = sck_sync[1] & ~sck_sync[2]; // mode 0 sample edge

	// bit counter, cs high drops any partial byte
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			bit_cnt  <= '0;
			byte_vld <= 1'b0;
		end
		else
		begin
			byte_vld <= 1'b0;
			if (!cs_act)
				bit_cnt <= '0;
			else if (sck_rise)
			begin
				bit_cnt  <= bit_cnt + 3'd1;
				byte_vld <= (bit_cnt == 3'd7); // eighth bit goes in now
			end
		end
	end

	always_ff @(posedge fclk)
	begin
		if (sck_rise)
			sr <= {sr[6:0], mosi_sync[1]};
	end

	// frame decoder, strobes are registered single pulses
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state      <= S_IDLE;
			cmd        <= '0;
			byte_cnt   <= '0;
			kbd_stb    <= 1'b0;
			mus_xstb   <= 1'b0;
			mus_ystb   <= 1'b0;
			mus_btnstb <= 1'b0;
			kj_stb     <= 1'b0;
		end
		else
		begin
			kbd_stb    <= 1'b0;
			mus_xstb   <= 1'b0;
			mus_ystb   <= 1'b0;
			mus_btnstb <= 1'b0;
			kj_stb     <= 1'b0;

			if (!cs_act)
				state <= S_IDLE; // end of frame or abort
			else
			begin
				case (state)
					S_IDLE: state <= S_CMD;
					S_CMD:
						if (byte_vld)
						begin
							cmd      <= sr;
							byte_cnt <= '0;
							case (sr)
								`CMD_KBD, `CMD_MUSX, `CMD_MUSY,
								`CMD_MUSBTN, `CMD_KJ: state <= S_DATA;
								default:              state <= S_SKIP; // unknown
							endcase
						end
					S_DATA:
						if (byte_vld)
						begin
							byte_cnt <= byte_cnt + 3'd1;
							case (cmd)
								`CMD_KBD:
									if (byte_cnt == 3'(`KBD_BYTES - 1)) // last key byte
									begin
										kbd_stb <= 1'b1;
										state   <= S_SKIP;
									end
								`CMD_MUSX:   mus_xstb   <= 1'b1;
								`CMD_MUSY:   mus_ystb   <= 1'b1;
								`CMD_MUSBTN: mus_btnstb <= 1'b1;
								default:     kj_stb     <= 1'b1; // CMD_KJ
							endcase
							if (cmd != `CMD_KBD)
								state <= S_SKIP; // single byte commands
						end
					default: ; // S_SKIP waits for cs to rise
				endcase
			end
		end
	end

	// data byte capture, valid alongside the strobe
	always_ff @(posedge fclk)
	begin
		if (state == S_DATA && byte_vld)
		begin
			mus_in <= sr;
			if (cmd == `CMD_KBD)
				kbd_hold <= {sr, kbd_hold[`KBD_BITS-1:8]}; // first byte ends in [7:0]
		end
	end

	assign kbd_in = kbd_hold;

endmodule

// ==== hdl/zkbdmus.sv ====
// key, mouse and kempston registers loaded from the spi strobes
// half-row and mouse byte selection by the port address high byte
`timescale 1ns/1ps

module zkbdmus (
	input  logic                  fclk,
	input  logic                  arst_n,
	input  zkbd_pkg::kbd_matrix_t kbd_in,
	input  logic                  kbd_stb,
	input  zkbd_pkg::mus_byte_t   mus_in,
	input  logic                  mus_xstb,
	input  logic                  mus_ystb,
	input  logic                  mus_btnstb,
	input  logic                  kj_stb,
	input  zkbd_pkg::zah_t        zah,
	output zkbd_pkg::kbd_row_t    kbd_data,
	output zkbd_pkg::mus_byte_t   mus_data,
	output zkbd_pkg::kj_t         kj_data
);
	import zkbd_pkg::*;

	kbd_matrix_t kbd;  // 1 = key down
	mus_byte_t   musx;
	mus_byte_t   musy;
	mus_byte_t   musbtn;
	kj_t         kj;
	kbd_row_t    kout; // wired-and of selected half-rows

	// register loads
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			kbd    <= '0; // nothing pressed
			musx   <= 8'hFF;
			musy   <= 8'hFF;
			musbtn <= 8'hFF; // buttons released
			kj     <= '0;
		end
		else
		begin
			if (kbd_stb)
				kbd <= kbd_in; // whole matrix at once
			if (mus_xstb)
				musx <= mus_in;
			if (mus_ystb)
				musy <= mus_in;
			if (mus_btnstb)
				musbtn <= mus_in;
			if (kj_stb)
				kj <= kj_t'(mus_in); // upper bits dropped in 5-bit mode
		end
	end

	// each low bit of zah enables one half-row
	always_comb
	begin
		kbd_row_t row;
		kout = '1;
		for (int r = 0; r < 8; r++)
		begin
			row  = {kbd[r], kbd[r+8], kbd[r+16], kbd[r+24], kbd[r+32]};
			kout = kout & ({5{zah[r]}} | ~row);
		end
	end

	assign kbd_data = kout;
	assign kj_data  = kj;

	// buttons at FADF, x at FBDF, y at FFDF
	assign mus_data = zah[0] ? (zah[2] ? musy : musx) : musbtn;

endmodule

// ==== hdl/zports_apb.sv ====
// apb slave answering cpu port reads
// keyboard, kempston joystick and kempston mouse decode, one wait state
`timescale 1ns/1ps
`include "zkbd_defs.svh"

module zports_apb (
	input  logic                 fclk,
	input  logic                 arst_n,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  zkbd_pkg::port_addr_t paddr,
	input  zkbd_pkg::mus_byte_t  pwdata, // nothing here is writable
	output zkbd_pkg::mus_byte_t  prdata,
	output logic                 pready,
	output logic                 pslverr,
	output zkbd_pkg::zah_t       zah,
	input  zkbd_pkg::kbd_row_t   kbd_data,
	input  zkbd_pkg::mus_byte_t  mus_data,
	input  zkbd_pkg::kj_t        kj_data
);
	import zkbd_pkg::*;

	zah_t      zal;     // address low byte
	logic      hit_kbd;
	logic      hit_kj;
	logic      hit_mus;
	logic      rd_ok;   // mapped read
	logic      access;  // first access cycle
	mus_byte_t rd_byte;

	assign zah = paddr[15:8]; // feeds half-row and mouse muxes
	assign zal = paddr[7:0];

	// port decode
	assign hit_kbd = (zal == `PORT_KBD_LO); // any high byte
	assign hit_kj  = (zal == `PORT_KJ);
	assign hit_mus = (zal == `PORT_MUS_LO) &&
	                 (zah == 8'hFA || zah == 8'hFB || zah == 8'hFF);

	assign rd_ok  = ~pwrite & (hit_kbd | hit_kj | hit_mus);
	assign access = psel & penable & ~pready; // not again in the wait cycle

	// answer byte
	always_comb
	begin
		if (hit_kbd)
			rd_byte = {3'b111, kbd_data}; // tape bit and spares read 1
		else if (hit_kj)
			rd_byte = mus_byte_t'(kj_data); // zero extended
		else
			rd_byte = mus_data;
	end

	// fixed single wait state
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pready  <= 1'b0;
			pslverr <= 1'b0;
		end
		else
		begin
			pready  <= access;           // one cycle pulse
			pslverr <= access & ~rd_ok;  // writes and unmapped ports
		end
	end

	always_ff @(posedge fclk)
	begin
		if (access)
			prdata <= rd_ok ? rd_byte : '0;
	end

endmodule

// ==== hdl/zkbd_top.sv ====
// top of the keyboard, mouse and joystick input path
// spi receiver, key and mouse registers, apb port decoder
`timescale 1ns/1ps

module zkbd_top (
	input  logic                 fclk,
	input  logic                 arst_n,
	input  logic                 spi_cs_n,
	input  logic                 spi_sck,
	input  logic                 spi_mosi,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  zkbd_pkg::port_addr_t paddr,
	input  zkbd_pkg::mus_byte_t  pwdata,
	output zkbd_pkg::mus_byte_t  prdata,
	output logic                 pready,
	output logic                 pslverr
);
	import zkbd_pkg::*;

	kbd_matrix_t kbd_in;
	logic        kbd_stb;
	mus_byte_t   mus_in;     // shared by mouse and joystick loads
	logic        mus_xstb;
	logic        mus_ystb;
	logic        mus_btnstb;
	logic        kj_stb;
	zah_t        zah;
	kbd_row_t    kbd_data;
	mus_byte_t   mus_data;
	kj_t         kj_data;

	slavespi u_spi (
		.fclk       (fclk),
		.arst_n     (arst_n),
		.spi_cs_n   (spi_cs_n),
		.spi_sck    (spi_sck),
		.spi_mosi   (spi_mosi),
		.kbd_in     (kbd_in),
		.kbd_stb    (kbd_stb),
		.mus_in     (mus_in),
		.mus_xstb   (mus_xstb),
		.mus_ystb   (mus_ystb),
		.mus_btnstb (mus_btnstb),
		.kj_stb     (kj_stb)
	);

	zkbdmus u_kbdmus (
		.fclk       (fclk),
		.arst_n     (arst_n),
		.kbd_in     (kbd_in),
		.kbd_stb    (kbd_stb),
		.mus_in     (mus_in),
		.mus_xstb   (mus_xstb),
		.mus_ystb   (mus_ystb),
		.mus_btnstb (mus_btnstb),
		.kj_stb     (kj_stb),
		.zah        (zah),
		.kbd_data   (kbd_data),
		.mus_data   (mus_data),
		.kj_data    (kj_data)
	);

	zports_apb u_ports (
		.fclk     (fclk),
		.arst_n   (arst_n),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.zah      (zah),
		.kbd_data (kbd_data),
		.mus_data (mus_data),
		.kj_data  (kj_data)
	);

endmodule

// ==== tests/zkbd_assert.sv ====
// protocol checks bound into the input path top
// apb wait state and error flag, strobe exclusivity, reset state
`timescale 1ns/1ps

module zkbd_assert (
	input logic fclk,
	input logic arst_n,
	input logic pready,
	input logic pslverr,
	input logic kbd_stb,
	input logic mus_xstb,
	input logic mus_ystb,
	input logic mus_btnstb,
	input logic kj_stb
);
	int fail_cnt = 0; // failed assertions so far

	// one wait state means a single cycle of pready
	a_pready_pulse: assert property (@(posedge fclk) disable iff (!arst_n) pready |=> !pready)
		else
		begin
			fail_cnt++;
			$error("pready stayed high for more than one cycle");
		end

	a_err_with_ready: assert property (@(posedge fclk) disable iff (!arst_n) pslverr |-> pready)
		else
		begin
			fail_cnt++;
			$error("pslverr high without pready");
		end

	// at most one load per cycle
	a_stb_onehot: assert property (@(posedge fclk) disable iff (!arst_n)
		$onehot0({kbd_stb, mus_xstb, mus_ystb, mus_btnstb, kj_stb}))
		else
		begin
			fail_cnt++;
			$error("more than one load strobe high at once");
		end

	a_reset_idle: assert property (@(posedge fclk) !arst_n |-> (!pready && !pslverr))
		else
		begin
			fail_cnt++; // apb outputs must sit low in reset
			$error("pready or pslverr high during reset");
		end

endmodule

// ==== tests/tb_zkbd.sv ====
// testbench for the keyboard, mouse and joystick input path
// spi and apb driver tasks, register model, read checks
`timescale 1ns/1ps
`include "zkbd_defs.svh"

module tb_zkbd;
	import zkbd_pkg::*;

	localparam int SEED    = 32'h7318;
	localparam int APB_TMO = 20; // cycles until pready
	localparam int VIS_TMO = 40; // reads until a loaded value shows
	localparam int NKBD    = 12; // random key frames

	logic        fclk;
	logic        arst_n;
	logic        spi_cs_n;
	logic        spi_sck;
	logic        spi_mosi;
	logic        psel;
	logic        penable;
	logic        pwrite;
	port_addr_t  paddr;
	mus_byte_t   pwdata;
	mus_byte_t   prdata;
	logic        pready;
	logic        pslverr;
	int          errors; // wrong values
	int          fails;  // timeouts
	kbd_matrix_t kbd_m;  // model of the registers
	mus_byte_t   musx_m;
	mus_byte_t   musy_m;
	mus_byte_t   musbtn_m;
	mus_byte_t   kj_m;   // byte as sent

	zkbd_top dut (
		.fclk (fclk), .arst_n (arst_n),
		.spi_cs_n (spi_cs_n), .spi_sck (spi_sck), .spi_mosi (spi_mosi),
		.psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
		.pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr)
	);

	bind zkbd_top zkbd_assert u_assert (
		.fclk (fclk), .arst_n (arst_n), .pready (pready), .pslverr (pslverr),
		.kbd_stb (kbd_stb), .mus_xstb (mus_xstb), .mus_ystb (mus_ystb),
		.mus_btnstb (mus_btnstb), .kj_stb (kj_stb)
	);

	initial
	begin
		fclk = 1'b0;
		forever #50 fclk = ~fclk; // 100 ns period
	end

	initial
	begin
		#20_000_000; // hard stop for a stuck run
		$display("simulation time limit reached");
		$display("SOME TESTS FAILED");
		$finish;
	end

	task automatic tick(input int n);
		repeat (n) @(posedge fclk);
		#5; // inputs change just after the edge
	endtask

	// mode 0 byte sent msb first with sck at fclk/8
	task automatic spi_byte(input mus_byte_t b);
		for (int i = 7; i >= 0; i--)
		begin
			spi_mosi = b[i];
			tick(4);
			spi_sck = 1'b1; // slave samples here
			tick(4);
			spi_sck = 1'b0;
		end
	endtask

	// command then n data bytes with byte k taken from data[8k+7:8k]
	task automatic spi_frame(input mus_byte_t cmd, input logic [47:0] data, input int n);
		spi_cs_n = 1'b0;
		tick(4);
		spi_byte(cmd);
		for (int k = 0; k < n; k++)
			spi_byte(data[8*k +: 8]);
		tick(4);
		spi_cs_n = 1'b1;
		tick(8); // decoder back in idle
	endtask

	task automatic send_one(input mus_byte_t cmd, input mus_byte_t b);
		spi_frame(cmd, {40'h0, b}, 1);
		case (cmd)
			`CMD_MUSX:   musx_m = b;
			`CMD_MUSY:   musy_m = b;
			`CMD_MUSBTN: musbtn_m = b;
			`CMD_KJ:     kj_m = b;
			default: ;
		endcase
	endtask

	task automatic apb_xfer(input logic wr, input port_addr_t addr,
		output mus_byte_t data, output logic serr);
		int n;
		psel    = 1'b1; // setup phase
		pwrite  = wr;
		paddr   = addr;
		pwdata  = 8'($urandom());
		tick(1);
		penable = 1'b1;
		for (n = 0; n < APB_TMO; n++)
		begin
			tick(1);
			if (pready)
				break;
		end
		if (n == APB_TMO)
		begin
			fails++;
			$display("no pready from port %h within %0d cycles", addr, APB_TMO);
		end
		else
		begin
			assert (n == 0) // one wait state only
			else
			begin
				errors++;
				$display("pready from port %h came %0d cycles late", addr, n);
			end
		end
		data    = prdata;
		serr    = pslverr;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic check_read(input port_addr_t addr, input mus_byte_t exp, input string name);
		mus_byte_t got;
		logic      serr;
		apb_xfer(1'b0, addr, got, serr);
		assert (got == exp)
		else
		begin
			errors++;
			$display("MISMATCH prdata (%s) port %h got %h exp %h", name, addr, got, exp);
		end
		assert (!serr)
		else
		begin
			errors++;
			$display("MISMATCH pslverr (%s) port %h got %h exp %h", name, addr, serr, 1'b0);
		end
	endtask

	// poll until the new value is visible and then check it
	task automatic await_read(input port_addr_t addr, input mus_byte_t exp, input string name);
		mus_byte_t got;
		logic      serr;
		int        n;
		for (n = 0; n < VIS_TMO; n++)
		begin
			apb_xfer(1'b0, addr, got, serr);
			if (got == exp)
				break;
		end
		if (n == VIS_TMO)
		begin
			fails++;
			$display("%s never showed the value sent over spi", name);
		end
		check_read(addr, exp, name);
	endtask

	task automatic check_error(input logic wr, input port_addr_t addr);
		mus_byte_t got;
		logic      serr;
		apb_xfer(wr, addr, got, serr);
		assert (serr)
		else
		begin
			errors++;
			$display("MISMATCH pslverr port %h got %h exp %h", addr, serr, 1'b1);
		end
		assert (got == 8'h00)
		else
		begin
			errors++;
			$display("MISMATCH prdata port %h got %h exp %h", addr, got, 8'h00);
		end
	endtask

	// key k lives in half-row k%8
	// answer bit 4 holds keys 0..7
	function automatic mus_byte_t kbd_expect(input zah_t hi);
		mus_byte_t b;
		b = 8'hFF;
		for (int k = 0; k < `KBD_BITS; k++)
			if (kbd_m[k] && !hi[k % 8])
				b[4 - k / 8] = 1'b0;
		return b;
	endfunction

	function automatic mus_byte_t kj_expect();
		return kj_m & 8'((1 << `KJ_BITS) - 1); // only KJ_BITS survive
	endfunction

	task automatic check_all();
		zah_t hi;
		for (int r = 0; r < 8; r++)
		begin
			hi = ~(8'd1 << r); // one half-row at a time
			check_read({hi, 8'hFE}, kbd_expect(hi), "kbd row");
		end
		check_read(16'hFADF, musbtn_m, "mouse buttons");
		check_read(16'hFBDF, musx_m, "mouse x");
		check_read(16'hFFDF, musy_m, "mouse y");
		check_read(16'h001F, kj_expect(), "kempston");
	endtask

	initial
	begin
		logic [47:0] d;
		zah_t        hi;
		void'($urandom(SEED));
		errors   = 0;
		fails    = 0;
		arst_n   = 1'b0;
		spi_cs_n = 1'b1;
		spi_sck  = 1'b0;
		spi_mosi = 1'b0;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		kbd_m    = '0;    // post-reset values
		musx_m   = 8'hFF;
		musy_m   = 8'hFF;
		musbtn_m = 8'hFF;
		kj_m     = 8'h00;
		tick(16);
		arst_n = 1'b1;
		tick(2);

		check_read(16'hFEFE, 8'hFF, "kbd after reset");
		check_all();

		// random key frames read back through single and multiple half-rows
		for (int i = 0; i < NKBD; i++)
		begin
			d     = {8'h00, $urandom(), 8'($urandom())};
			spi_frame(`CMD_KBD, d, `KBD_BYTES);
			kbd_m = d[39:0];
			await_read(16'h00FE, kbd_expect(8'h00), "kbd all rows");
			hi    = ~(8'd1 << (i % 8));
			check_read({hi, 8'hFE}, kbd_expect(hi), "kbd one row");
			for (int j = 0; j < 4; j++)
			begin
				hi = 8'($urandom()) & 8'($urandom()); // usually several rows
				check_read({hi, 8'hFE}, kbd_expect(hi), "kbd rows");
			end
		end

		send_one(`CMD_MUSX, 8'($urandom()));
		await_read(16'hFBDF, musx_m, "mouse x");
		send_one(`CMD_MUSY, 8'($urandom()));
		await_read(16'hFFDF, musy_m, "mouse y");
		send_one(`CMD_MUSBTN, 8'($urandom()));
		await_read(16'hFADF, musbtn_m, "mouse buttons");

		send_one(`CMD_KJ, 8'($urandom()) | 8'hE0); // upper bits set
		await_read(16'h001F, kj_expect(), "kempston");
		check_read({8'($urandom()), 8'h1F}, kj_expect(), "kempston any high byte");

		// frames that must not disturb the registers
		d = {$urandom(), 16'($urandom())};
		spi_frame(`CMD_KBD, d, 3); // cut short by cs
		check_all();
		spi_frame(8'h55, d, 2); // unknown command
		check_all();
		spi_frame(`CMD_MUSX, d, 4); // first byte counts
		musx_m = d[7:0];
		await_read(16'hFBDF, musx_m, "mouse x trailing");
		check_all();
		d     = {$urandom(), 16'($urandom())};
		spi_frame(`CMD_KBD, d, 6);
		kbd_m = d[39:0];
		await_read(16'h00FE, kbd_expect(8'h00), "kbd trailing");
		check_all();

		check_error(1'b1, 16'h00FE); // nothing is writable
		check_error(1'b1, 16'hFBDF);
		check_error(1'b0, 16'h12DF); // mouse low byte, wrong high byte
		check_error(1'b0, 16'h0000);

		tick(4);
		$display("errors %0d, timeouts %0d, assertion failures %0d",
			errors, fails, dut.u_assert.fail_cnt);
		if (errors == 0 && fails == 0 && dut.u_assert.fail_cnt == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+include
hdl/zkbd_pkg.sv
hdl/slavespi.sv
hdl/zkbdmus.sv
hdl/zports_apb.sv
hdl/zkbd_top.sv
tests/zkbd_assert.sv
tests/tb_zkbd.sv

// ==== Makefile ====
# verilator flow for the keyboard, mouse and joystick input path
TOP = tb_zkbd

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
